// ==== common/core_pkg.sv ====
package core_pkg;

  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;
  typedef logic [4:0] reg_idx_t;
  typedef logic [31:0] inst_t;

  localparam addr_t reset_pc = 32'h0000_0000;
  localparam addr_t inst_bytes = 32'd4;
  // ADDI x0, x0, 0
  localparam inst_t nop_inst = 32'h0000_0013;

  typedef enum logic [6:0] {
    OpReg    = 7'b0110011,
    OpImm    = 7'b0010011,
    OpLoad   = 7'b0000011,
    OpStore  = 7'b0100011,
    OpBranch = 7'b1100011
  } opcode_e;

  typedef enum logic [2:0] {
    AluAdd,
    AluSub,
    AluAnd,
    AluOr,
    AluXor,
    AluSlt
  } alu_op_e;

  typedef enum logic [1:0] {
    FwdNone,
    FwdMem,
    FwdWb
  } fwd_sel_e;

  typedef enum logic {
    WbAlu,
    WbMem
  } wb_src_e;

  typedef struct packed {
    addr_t pc;
    inst_t inst;
  } if_id_t;

  typedef struct packed {
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    word_t    operand_a;
    word_t    operand_b;
    word_t    imm;
    alu_op_e  alu_op;
    logic     use_imm;
    logic     reg_we;
    logic     mem_rd;
    logic     mem_wr;
    wb_src_e  wb_src;
  } id_ex_t;

  typedef struct packed {
    reg_idx_t rd;
    word_t    alu_y;
    word_t    store_data;
    logic     reg_we;
    logic     mem_rd;
    logic     mem_wr;
    wb_src_e  wb_src;
  } ex_mem_t;

  typedef struct packed {
    reg_idx_t rd;
    word_t    alu_y;
    word_t    load_data;
    logic     reg_we;
    wb_src_e  wb_src;
  } mem_wb_t;

  // Operand select shared by the ID and EX forwarding paths
  function automatic word_t fwd_pick(fwd_sel_e sel, word_t base, word_t mem_val, word_t wb_val);
    case (sel)
      FwdMem:  return mem_val;
      FwdWb:   return wb_val;
      default: return base;
    endcase
  endfunction

endpackage

// ==== common/hazard_if.sv ====
interface hazard_if;

  // Source indices in ID and EX
  core_pkg::reg_idx_t rs1_id;
  core_pkg::reg_idx_t rs2_id;
  logic               branch_id;
  core_pkg::reg_idx_t rs1_ex;
  core_pkg::reg_idx_t rs2_ex;

  // Destinations further down the pipe
  core_pkg::reg_idx_t rd_ex;
  logic               mem_rd_ex;
  logic               reg_we_ex;
  core_pkg::reg_idx_t rd_mem;
  logic               mem_rd_mem;
  logic               reg_we_mem;
  core_pkg::reg_idx_t rd_wb;
  logic               reg_we_wb;

  logic               stall;
  logic               flush_ex;
  core_pkg::fwd_sel_e fwd_a_ex;
  core_pkg::fwd_sel_e fwd_b_ex;
  core_pkg::fwd_sel_e fwd_a_id;
  core_pkg::fwd_sel_e fwd_b_id;

  modport stages (
    output rs1_id, rs2_id, branch_id, rs1_ex, rs2_ex,
    output rd_ex, mem_rd_ex, reg_we_ex, rd_mem, mem_rd_mem, reg_we_mem, rd_wb, reg_we_wb,
    input  stall, flush_ex, fwd_a_ex, fwd_b_ex, fwd_a_id, fwd_b_id
  );

  modport hazard (
    input  rs1_id, rs2_id, branch_id, rs1_ex, rs2_ex,
    input  rd_ex, mem_rd_ex, reg_we_ex, rd_mem, mem_rd_mem, reg_we_mem, rd_wb, reg_we_wb,
    output stall, flush_ex, fwd_a_ex, fwd_b_ex, fwd_a_id, fwd_b_id
  );

  modport fetch (
    input stall
  );

endinterface

// ==== pipeline/fetch_stage.sv ====
module fetch_stage (
  input  logic              clock,
  input  logic              reset,
  input  logic              mem_busy,
  hazard_if.fetch           hz,
  input  logic              branch_taken,
  input  core_pkg::addr_t   branch_target,
  output core_pkg::addr_t   inst_addr,
  input  core_pkg::inst_t   inst,
  output core_pkg::if_id_t  if_id
);

  core_pkg::addr_t pc;
  logic            advance;

  assign advance   = !mem_busy && !hz.stall;
  assign inst_addr = pc;

  always_ff @(posedge clock) begin
    if (reset) begin
      pc <= core_pkg::reset_pc;
    end else if (advance) begin
      pc <= branch_taken ? branch_target : pc + core_pkg::inst_bytes;
    end
  end

  // Taken branch squashes the fetched word
  always_ff @(posedge clock) begin
    if (reset) begin
      if_id.pc   <= core_pkg::reset_pc;
      if_id.inst <= core_pkg::nop_inst;
    end else if (advance) begin
      if_id.pc   <= pc;
      if_id.inst <= branch_taken ? core_pkg::nop_inst : inst;
    end
  end

endmodule

// ==== pipeline/decode_stage.sv ====
module decode_stage (
  input  logic               clock,
  input  logic               reset,
  input  logic               mem_busy,
  hazard_if.stages           hz,
  input  core_pkg::if_id_t   if_id,
  input  logic               wb_reg_we,
  input  core_pkg::reg_idx_t wb_rd,
  input  core_pkg::word_t    wb_data,
  input  core_pkg::word_t    mem_fwd_data,
  output logic               branch_taken,
  output core_pkg::addr_t    branch_target,
  output core_pkg::id_ex_t   id_ex
);

  core_pkg::word_t    regs [1:31];
  core_pkg::opcode_e  opcode;
  logic [2:0]         funct3;
  core_pkg::reg_idx_t rs1;
  core_pkg::reg_idx_t rs2;
  core_pkg::word_t    rf_a;
  core_pkg::word_t    rf_b;
  core_pkg::word_t    op_a;
  core_pkg::word_t    op_b;
  core_pkg::word_t    imm_i;
  core_pkg::word_t    imm_s;
  core_pkg::word_t    imm_b;
  core_pkg::id_ex_t   id_ex_d;
  logic               uses_rs2;
  logic               is_branch;

  assign opcode = core_pkg::opcode_e'(if_id.inst[6:0]);
  assign funct3 = if_id.inst[14:12];
  assign rs1    = if_id.inst[19:15];
  // Masked so immediate bits never look like a dependency
  assign rs2    = uses_rs2 ? if_id.inst[24:20] : '0;

  assign uses_rs2  = (opcode == core_pkg::OpReg) || (opcode == core_pkg::OpStore) ||
                     (opcode == core_pkg::OpBranch);
  assign is_branch = (opcode == core_pkg::OpBranch);

  assign imm_i = {{20{if_id.inst[31]}}, if_id.inst[31:20]};
  assign imm_s = {{20{if_id.inst[31]}}, if_id.inst[31:25], if_id.inst[11:7]};
  assign imm_b = {{19{if_id.inst[31]}}, if_id.inst[31], if_id.inst[7],
                  if_id.inst[30:25], if_id.inst[11:8], 1'b0};

  always_ff @(posedge clock) begin
    if (wb_reg_we && wb_rd != '0) begin
      regs[wb_rd] <= wb_data;
    end
  end

  // Write-through so WB and ID can share a cycle
  assign rf_a = (rs1 == '0) ? '0 : (wb_reg_we && wb_rd == rs1) ? wb_data : regs[rs1];
  assign rf_b = (rs2 == '0) ? '0 : (wb_reg_we && wb_rd == rs2) ? wb_data : regs[rs2];
  assign op_a = core_pkg::fwd_pick(hz.fwd_a_id, rf_a, mem_fwd_data, wb_data);
  assign op_b = core_pkg::fwd_pick(hz.fwd_b_id, rf_b, mem_fwd_data, wb_data);

  always_comb begin
    id_ex_d         = '0;
    id_ex_d.rs1     = rs1;
    id_ex_d.rs2     = rs2;
    id_ex_d.rd      = if_id.inst[11:7];
    id_ex_d.operand_a = op_a;
    id_ex_d.operand_b = op_b;
    id_ex_d.imm     = imm_i;
    id_ex_d.alu_op  = core_pkg::AluAdd;
    id_ex_d.wb_src  = core_pkg::WbAlu;
    case (opcode)
      core_pkg::OpReg, core_pkg::OpImm: begin
        id_ex_d.reg_we  = 1'b1;
        id_ex_d.use_imm = (opcode == core_pkg::OpImm);
        case (funct3)
          3'b010:  id_ex_d.alu_op = core_pkg::AluSlt;
          3'b100:  id_ex_d.alu_op = core_pkg::AluXor;
          3'b110:  id_ex_d.alu_op = core_pkg::AluOr;
          3'b111:  id_ex_d.alu_op = core_pkg::AluAnd;
          default: id_ex_d.alu_op = (uses_rs2 && if_id.inst[30]) ? core_pkg::AluSub
                                                                  : core_pkg::AluAdd;
        endcase
      end
      core_pkg::OpLoad: begin
        id_ex_d.reg_we  = 1'b1;
        id_ex_d.use_imm = 1'b1;
        id_ex_d.mem_rd  = 1'b1;
        id_ex_d.wb_src  = core_pkg::WbMem;
      end
      core_pkg::OpStore: begin
        id_ex_d.use_imm = 1'b1;
        id_ex_d.mem_wr  = 1'b1;
        id_ex_d.imm     = imm_s;
      end
      default: ;
    endcase
    // Bubble while the hazard unit holds ID
    if (hz.flush_ex) begin
      id_ex_d.reg_we = 1'b0;
      id_ex_d.mem_rd = 1'b0;
      id_ex_d.mem_wr = 1'b0;
    end
  end

  assign hz.rs1_id    = rs1;
  assign hz.rs2_id    = rs2;
  assign hz.branch_id = is_branch;

  // funct3[0] picks BNE over BEQ
  assign branch_taken  = is_branch && !hz.stall && ((op_a != op_b) == funct3[0]);
  assign branch_target = if_id.pc + imm_b;

  always_ff @(posedge clock) begin
    if (reset) begin
      id_ex.reg_we <= 1'b0;
      id_ex.mem_rd <= 1'b0;
      id_ex.mem_wr <= 1'b0;
    end else if (!mem_busy) begin
      id_ex <= id_ex_d;
    end
  end

endmodule

// ==== pipeline/execute_stage.sv ====
module execute_stage (
  input  logic              clock,
  input  logic              reset,
  input  logic              mem_busy,
  hazard_if.stages          hz,
  input  core_pkg::id_ex_t  id_ex,
  input  core_pkg::word_t   mem_fwd_data,
  input  core_pkg::word_t   wb_data,
  output core_pkg::ex_mem_t ex_mem
);

  core_pkg::word_t fwd_a;
  core_pkg::word_t fwd_b;
  core_pkg::word_t alu_b;
  core_pkg::word_t alu_y;

  assign fwd_a = core_pkg::fwd_pick(hz.fwd_a_ex, id_ex.operand_a, mem_fwd_data, wb_data);
  assign fwd_b = core_pkg::fwd_pick(hz.fwd_b_ex, id_ex.operand_b, mem_fwd_data, wb_data);
  assign alu_b = id_ex.use_imm ? id_ex.imm : fwd_b;

  always_comb begin
    case (id_ex.alu_op)
      core_pkg::AluSub: alu_y = fwd_a - alu_b;
      core_pkg::AluAnd: alu_y = fwd_a & alu_b;
      core_pkg::AluOr:  alu_y = fwd_a | alu_b;
      core_pkg::AluXor: alu_y = fwd_a ^ alu_b;
      core_pkg::AluSlt: alu_y = {31'b0, $signed(fwd_a) < $signed(alu_b)};
      default:          alu_y = fwd_a + alu_b;
    endcase
  end

  assign hz.rs1_ex    = id_ex.rs1;
  assign hz.rs2_ex    = id_ex.rs2;
  assign hz.rd_ex     = id_ex.rd;
  assign hz.mem_rd_ex = id_ex.mem_rd;
  assign hz.reg_we_ex = id_ex.reg_we;

  always_ff @(posedge clock) begin
    if (reset) begin
      ex_mem.reg_we <= 1'b0;
      ex_mem.mem_rd <= 1'b0;
      ex_mem.mem_wr <= 1'b0;
    end else if (!mem_busy) begin
      ex_mem.rd         <= id_ex.rd;
      ex_mem.alu_y      <= alu_y;
      // Forwarded rs2 is the store value
      ex_mem.store_data <= fwd_b;
      ex_mem.reg_we     <= id_ex.reg_we;
      ex_mem.mem_rd     <= id_ex.mem_rd;
      ex_mem.mem_wr     <= id_ex.mem_wr;
      ex_mem.wb_src     <= id_ex.wb_src;
    end
  end

endmodule

// ==== pipeline/memory_stage.sv ====
module memory_stage (
  input  logic               clock,
  input  logic               reset,
  hazard_if.stages           hz,
  input  core_pkg::ex_mem_t  ex_mem,
  output logic               mem_busy,
  output core_pkg::word_t    mem_fwd_data,
  output logic               wb_reg_we,
  output core_pkg::reg_idx_t wb_rd,
  output core_pkg::word_t    wb_data,
  output logic               wb_cyc,
  output logic               wb_stb,
  output logic               wb_we,
  output core_pkg::addr_t    wb_adr,
  output core_pkg::word_t    wb_dat_o,
  input  core_pkg::word_t    wb_dat_i,
  input  logic               wb_ack
);

  core_pkg::mem_wb_t mem_wb;

  // Bus signals come straight from EX/MEM, which holds while busy
  assign wb_stb   = ex_mem.mem_rd || ex_mem.mem_wr;
  assign wb_cyc   = wb_stb;
  assign wb_we    = ex_mem.mem_wr;
  assign wb_adr   = ex_mem.alu_y;
  assign wb_dat_o = ex_mem.store_data;
  assign mem_busy = wb_stb && !wb_ack;

  assign mem_fwd_data = ex_mem.alu_y;

  assign hz.rd_mem     = ex_mem.rd;
  assign hz.mem_rd_mem = ex_mem.mem_rd;
  assign hz.reg_we_mem = ex_mem.reg_we;
  assign hz.rd_wb      = mem_wb.rd;
  assign hz.reg_we_wb  = mem_wb.reg_we;

  always_ff @(posedge clock) begin
    if (reset) begin
      mem_wb.reg_we <= 1'b0;
    end else if (!mem_busy) begin
      mem_wb.rd        <= ex_mem.rd;
      mem_wb.alu_y     <= ex_mem.alu_y;
      mem_wb.load_data <= wb_dat_i;
      mem_wb.reg_we    <= ex_mem.reg_we;
      mem_wb.wb_src    <= ex_mem.wb_src;
    end
  end

  assign wb_reg_we = mem_wb.reg_we;
  assign wb_rd     = mem_wb.rd;
  assign wb_data   = (mem_wb.wb_src == core_pkg::WbMem) ? mem_wb.load_data : mem_wb.alu_y;

endmodule

// ==== src/hazard_unit.sv ====
module hazard_unit (
  hazard_if.hazard hz
);

  logic load_use;
  logic branch_dep;

  // x0 is never a real dependency
  function automatic logic hit(core_pkg::reg_idx_t src, core_pkg::reg_idx_t dst, logic en);
    return en && (src != '0) && (src == dst);
  endfunction

  // MEM wins over WB since it holds the younger result
  function automatic core_pkg::fwd_sel_e pick(core_pkg::reg_idx_t src, logic mem_ok);
    if (hit(src, hz.rd_mem, hz.reg_we_mem && mem_ok)) return core_pkg::FwdMem;
    if (hit(src, hz.rd_wb, hz.reg_we_wb)) return core_pkg::FwdWb;
    return core_pkg::FwdNone;
  endfunction

  assign load_use = hit(hz.rs1_id, hz.rd_ex, hz.mem_rd_ex) ||
                    hit(hz.rs2_id, hz.rd_ex, hz.mem_rd_ex);

  // Branch compares in ID, so results still in EX or loads in MEM are not ready
  assign branch_dep = hz.branch_id && (hit(hz.rs1_id, hz.rd_ex, hz.reg_we_ex) ||
                                       hit(hz.rs2_id, hz.rd_ex, hz.reg_we_ex) ||
                                       hit(hz.rs1_id, hz.rd_mem, hz.mem_rd_mem) ||
                                       hit(hz.rs2_id, hz.rd_mem, hz.mem_rd_mem));

  assign hz.stall    = load_use || branch_dep;
  assign hz.flush_ex = hz.stall;

  assign hz.fwd_a_ex = pick(hz.rs1_ex, 1'b1);
  assign hz.fwd_b_ex = pick(hz.rs2_ex, 1'b1);
  // alu_y of a load in MEM is only its address
  assign hz.fwd_a_id = pick(hz.rs1_id, !hz.mem_rd_mem);
  assign hz.fwd_b_id = pick(hz.rs2_id, !hz.mem_rd_mem);

endmodule

// ==== src/core_top.sv ====
module core_top (
  input  logic            clock,
  input  logic            reset,
  output core_pkg::addr_t inst_addr,
  input  core_pkg::inst_t inst,
  output logic            wb_cyc,
  output logic            wb_stb,
  output logic            wb_we,
  output core_pkg::addr_t wb_adr,
  output core_pkg::word_t wb_dat_o,
  input  core_pkg::word_t wb_dat_i,
  input  logic            wb_ack
);

  core_pkg::if_id_t   if_id;
  core_pkg::id_ex_t   id_ex;
  core_pkg::ex_mem_t  ex_mem;
  logic               mem_busy;
  logic               branch_taken;
  core_pkg::addr_t    branch_target;
  logic               wb_reg_we;
  core_pkg::reg_idx_t wb_rd;
  core_pkg::word_t    wb_data;
  core_pkg::word_t    mem_fwd_data;

  hazard_if hz ();

  fetch_stage u_fetch (
    .clock         (clock),
    .reset         (reset),
    .mem_busy      (mem_busy),
    .hz            (hz),
    .branch_taken  (branch_taken),
    .branch_target (branch_target),
    .inst_addr     (inst_addr),
    .inst          (inst),
    .if_id         (if_id)
  );

  decode_stage u_decode (
    .clock         (clock),
    .reset         (reset),
    .mem_busy      (mem_busy),
    .hz            (hz),
    .if_id         (if_id),
    .wb_reg_we     (wb_reg_we),
    .wb_rd         (wb_rd),
    .wb_data       (wb_data),
    .mem_fwd_data  (mem_fwd_data),
    .branch_taken  (branch_taken),
    .branch_target (branch_target),
    .id_ex         (id_ex)
  );

  execute_stage u_execute (
    .clock        (clock),
    .reset        (reset),
    .mem_busy     (mem_busy),
    .hz           (hz),
    .id_ex        (id_ex),
    .mem_fwd_data (mem_fwd_data),
    .wb_data      (wb_data),
    .ex_mem       (ex_mem)
  );

  memory_stage u_memory (
    .clock        (clock),
    .reset        (reset),
    .hz           (hz),
    .ex_mem       (ex_mem),
    .mem_busy     (mem_busy),
    .mem_fwd_data (mem_fwd_data),
    .wb_reg_we    (wb_reg_we),
    .wb_rd        (wb_rd),
    .wb_data      (wb_data),
    .wb_cyc       (wb_cyc),
    .wb_stb       (wb_stb),
    .wb_we        (wb_we),
    .wb_adr       (wb_adr),
    .wb_dat_o     (wb_dat_o),
    .wb_dat_i     (wb_dat_i),
    .wb_ack       (wb_ack)
  );

  hazard_unit u_hazard (
    .hz (hz)
  );

endmodule

// ==== tests/clock_gen.sv ====
module clock_gen (
  output logic clock,
  output logic reset
);

  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  // Released on a rising edge after 10 cycles
  initial begin
    reset = 1'b1;
    repeat (10) @(posedge clock);
    reset <= 1'b0;
  end

endmodule

// ==== tests/core_asserts.sv ====
module core_asserts (
  input logic            clock,
  input logic            reset,
  input logic            wb_cyc,
  input logic            wb_stb,
  input logic            wb_we,
  input core_pkg::addr_t wb_adr,
  input core_pkg::word_t wb_dat_o,
  input logic            wb_ack
);

  timeunit 1ns;
  timeprecision 1ps;

  int failures = 0;

  stb_needs_cyc: assert property (@(posedge clock) disable iff (reset) wb_stb |-> wb_cyc)
    else begin
      $error("wb_stb high without wb_cyc");
      failures++;
    end

  // Request fields hold until the slave acks
  request_stable: assert property (@(posedge clock) disable iff (reset)
      (wb_stb && !wb_ack) |=> ($stable(wb_adr) && $stable(wb_we) && $stable(wb_dat_o)))
    else begin
      $error("Wishbone request changed before ack");
      failures++;
    end

  idle_after_reset: assert property (@(posedge clock) $fell(reset) |-> !wb_cyc)
    else begin
      $error("wb_cyc high in the first cycle after reset");
      failures++;
    end

endmodule

bind memory_stage core_asserts u_asserts (
  .clock    (clock),
  .reset    (reset),
  .wb_cyc   (wb_cyc),
  .wb_stb   (wb_stb),
  .wb_we    (wb_we),
  .wb_adr   (wb_adr),
  .wb_dat_o (wb_dat_o),
  .wb_ack   (wb_ack)
);

// ==== tests/tb_top.sv ====
module tb_top;

  timeunit 1ns;
  timeprecision 1ps;

  logic            clock;
  logic            reset;
  core_pkg::addr_t inst_addr;
  core_pkg::inst_t inst;
  logic            wb_cyc;
  logic            wb_stb;
  logic            wb_we;
  core_pkg::addr_t wb_adr;
  core_pkg::word_t wb_dat_o;
  core_pkg::word_t wb_dat_i;
  logic            wb_ack;

  core_pkg::inst_t rom [0:63];
  core_pkg::word_t dmem [core_pkg::addr_t];
  core_pkg::addr_t exp_addr [$];
  core_pkg::word_t exp_data [$];
  int              errors = 0;
  int              stores_seen = 0;
  int              wait_left = 0;
  int              delay_now;
  logic            started = 1'b0;

  clock_gen u_clock (.clock(clock), .reset(reset));

  core_top dut (
    .clock(clock), .reset(reset), .inst_addr(inst_addr), .inst(inst),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
    .wb_dat_o(wb_dat_o), .wb_dat_i(wb_dat_i), .wb_ack(wb_ack)
  );

  // Instruction ROM, combinational read
  assign inst = rom[inst_addr[7:2]];

  function automatic core_pkg::word_t read_mem(core_pkg::addr_t a);
    if (dmem.exists(a)) return dmem[a];
    return a ^ 32'ha5a5_5a5a;
  endfunction

  task automatic check_addr(string name, core_pkg::addr_t got, core_pkg::addr_t exp);
    if (got !== exp) begin
      $display("Error: %0t %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_word(string name, core_pkg::word_t got, core_pkg::word_t exp);
    if (got !== exp) begin
      $display("Error: %0t %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic load_stim();
    int    fd;
    string line;
    byte   kind;
    logic [31:0] a;
    logic [31:0] d;
    for (int i = 0; i < 64; i++) rom[i] = core_pkg::nop_inst;
    fd = $fopen("tests/core_stim.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file");
      errors++;
      return;
    end
    while ($fgets(line, fd) > 0) begin
      if (line.len() > 0 && line[0] != "#" && $sscanf(line, "%c %h %h", kind, a, d) == 3) begin
        case (kind)
          "I": rom[a[7:2]] = d;
          "D": dmem[a] = d;
          "S": begin
            exp_addr.push_back(a);
            exp_data.push_back(d);
          end
          default: ;
        endcase
      end
    end
    $fclose(fd);
  endtask

  // Wishbone slave with a random ack delay of 0 to 3 cycles
  initial begin
    wb_ack   = 1'b0;
    wb_dat_i = '0;
    void'($urandom(32'h462048a7));
    forever begin
      @(posedge clock);
      if (reset) begin
        wb_ack  <= 1'b0;
        started <= 1'b0;
      end else if (wb_ack) begin
        wb_ack  <= 1'b0;
        started <= 1'b0;
      end else if (wb_cyc && wb_stb) begin
        delay_now = started ? wait_left : int'($urandom % 4);
        if (delay_now == 0) begin
          wb_ack <= 1'b1;
          if (wb_we) begin
            if (stores_seen >= exp_addr.size()) begin
              $display("Unexpected store to %h at %0t", wb_adr, $time);
              errors++;
            end else begin
              check_addr("wb_adr", wb_adr, exp_addr[stores_seen]);
              check_word("wb_dat_o", wb_dat_o, exp_data[stores_seen]);
            end
            stores_seen++;
            dmem[wb_adr] = wb_dat_o;
          end else begin
            wb_dat_i <= read_mem(wb_adr);
          end
        end else begin
          wait_left <= delay_now - 1;
          started   <= 1'b1;
        end
      end
    end
  end

  initial begin
    int cycles;
    int total;
    load_stim();
    cycles = 0;
    while (reset !== 1'b0 && cycles < 100) begin
      @(posedge clock);
      cycles++;
    end
    if (reset !== 1'b0) begin
      $display("Reset never released");
      errors++;
    end
    cycles = 0;
    while (stores_seen < exp_addr.size() && cycles < 2000) begin
      @(posedge clock);
      cycles++;
    end
    if (stores_seen < exp_addr.size()) begin
      $display("Timeout with %0d of %0d stores seen", stores_seen, exp_addr.size());
      errors++;
    end else begin
      // Room for stray stores after the last expected one
      repeat (20) @(posedge clock);
    end
    total = errors + dut.u_memory.u_asserts.failures;
    $display("Errors: %0d checks, %0d assertions, %0d stores seen", errors,
             dut.u_memory.u_asserts.failures, stores_seen);
    if (total == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== tests/core_stim.txt ====
# I <byte addr> <instruction>, D <byte addr> <initial data word>
# S <store addr> <store data>, expected in program order
I 00 00500093
I 04 00c00113
I 08 002081b3
I 0c 40118233
I 10 0041e333
I 14 00602023
I 18 0020c3b3
I 1c 0020a433
I 20 00702223
I 24 00802423
I 28 04002483
I 2c 00148533
I 30 00a02623
I 34 00700013
I 38 00002823
I 3c 00500593
I 40 00158463
I 44 00102a23
I 48 00159463
I 4c 00202a23
I 50 00259463
I 54 00102c23
I 58 00258463
I 5c 00b02c23
I 60 04402603
I 64 00c02e23
I 68 00000063
D 40 00000100
D 44 deadbeef
S 00 0000001d
S 04 00000009
S 08 00000001
S 0c 00000105
S 10 00000000
S 14 0000000c
S 18 00000005
S 1c deadbeef

// ==== tb.f ====
common/core_pkg.sv
common/hazard_if.sv
pipeline/fetch_stage.sv
pipeline/decode_stage.sv
pipeline/execute_stage.sv
pipeline/memory_stage.sv
src/hazard_unit.sv
src/core_top.sv
tests/clock_gen.sv
tests/core_asserts.sv
tests/tb_top.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_top -f tb.f --Mdir obj_dir -o tb_sim
./obj_dir/tb_sim | tee sim.log

if grep -qx "STATUS: PASS" sim.log; then
  exit 0
fi
exit 1
